// File: include/w5300_defs.svh
`ifndef W5300_DEFS_SVH
`define W5300_DEFS_SVH

// common registers, word addresses in 8-bit bus mode
`define W5300_IR           10'h002
`define W5300_IMR          10'h004
`define W5300_SHAR         10'h008
`define W5300_GAR          10'h010
`define W5300_SUBR         10'h014
`define W5300_SIPR         10'h018

// socket 0 registers
`define W5300_S0_MR        10'h200
`define W5300_S0_CR        10'h202
`define W5300_S0_IMR       10'h204
`define W5300_S0_IR        10'h206
`define W5300_S0_SSR       10'h208
`define W5300_S0_PORTR     10'h20A
`define W5300_S0_RX_RSR    10'h228
`define W5300_S0_RX_RSR2   10'h22A
`define W5300_S0_RX_FIFOR  10'h230

// register values for setup
`define IMR_S0_EN          16'h0001
`define SN_MR_UDP          16'h0002
`define SN_CR_OPEN         16'h0001
`define S0_RECV_IRQ        16'h0004
`define UDP_PORT           16'h1388
`define SOCK_UDP           8'h22

// network identity 00:08:dc:01:02:03, 192.168.0.1, 255.255.255.0, 192.168.0.7
`define MAC_W0             16'h0008
`define MAC_W1             16'hdc01
`define MAC_W2             16'h0203
`define GAR_W0             16'hc0a8
`define GAR_W1             16'h0001
`define SUBR_W0            16'hffff
`define SUBR_W1            16'hff00
`define SIPR_W0            16'hc0a8
`define SIPR_W1            16'h0007

// sequencing limits
`define INIT_STEPS         14
`define SSR_RETRIES        3
`define SSR_WAIT           100
`define UDP_INFO_LEN       8

// bus phases in clocks
`define BUS_SETUP          1
`define BUS_STROBE         2
`define BUS_HOLD           1

`endif

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_w5300_udp_bridge -o tb_sim \
	|| { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -q "sim passed" && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: src.f
+incdir+include
verilog/w5300_pkg.sv
verilog/w5300_bus.sv
verilog/w5300_init_rom.sv
verilog/w5300_seq.sv
verilog/udp_unpack.sv
verilog/w5300_udp_bridge.sv
test/w5300_model.sv
test/tb_w5300_udp_bridge.sv

// File: test/tb_w5300_udp_bridge.sv
`include "w5300_defs.svh"

module tb_w5300_udp_bridge;
	timeunit 1ns;
	timeprecision 100ps;

	// two setups with SSR waits plus four packets of up to 64 bytes
	localparam int MAX_CYCLES = 20000;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        int_n;
	logic [9:0]  addr;
	logic        cs;
	logic        rd;
	logic        wr;
	wire  [7:0]  data;
	logic        payload_valid;
	logic [7:0]  payload_data;
	logic        payload_ready = 1'b0;
	logic        rx_done;
	logic        init_done;
	logic        init_fail;

	logic        refuse_open;
	logic        pkt_wr;
	logic [7:0]  pkt_byte;
	logic        pkt_go;
	logic [16:0] pkt_len;
	logic [7:0]  rd_byte;
	logic        log_valid;
	logic [9:0]  log_addr;
	logic [15:0] log_data;
	logic [7:0]  ssr_reads;

	logic        ready_en = 1'b0;
	logic        take_q = 1'b0;  // byte taken on the previous clock
	logic [7:0]  want_byte;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          done_count = 0;
	logic [7:0]  exp_bytes [$];
	logic [9:0]  log_a [$];
	logic [15:0] log_d [$];
	logic [9:0]  want_a [$];
	logic [15:0] want_d [$];

	w5300_udp_bridge UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.int_n         (int_n),
		.addr          (addr),
		.cs            (cs),
		.rd            (rd),
		.wr            (wr),
		.data          (data),
		.payload_valid (payload_valid),
		.payload_data  (payload_data),
		.payload_ready (payload_ready),
		.rx_done       (rx_done),
		.init_done     (init_done),
		.init_fail     (init_fail)
	);

	w5300_model chip (
		.clk         (clk),
		.rst_n       (rst_n),
		.addr        (addr),
		.cs          (cs),
		.rd          (rd),
		.wr          (wr),
		.data        (data),
		.int_n       (int_n),
		.rd_byte     (rd_byte),
		.refuse_open (refuse_open),
		.pkt_wr      (pkt_wr),
		.pkt_byte    (pkt_byte),
		.pkt_go      (pkt_go),
		.pkt_len     (pkt_len),
		.log_valid   (log_valid),
		.log_addr    (log_addr),
		.log_data    (log_data),
		.ssr_reads   (ssr_reads)
	);

	always #20 clk = ~clk;

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			$display("FAIL %0t: %s", $time, what);
		end
	endtask

	task automatic expect_write(input logic [9:0] a, input logic [15:0] d);
		want_a.push_back(a);
		want_d.push_back(d);
	endtask

	task automatic load_setup_list();
		expect_write(`W5300_IMR, 16'h0001);
		expect_write(`W5300_SHAR, `MAC_W0);
		expect_write(`W5300_SHAR + 10'd2, `MAC_W1);
		expect_write(`W5300_SHAR + 10'd4, `MAC_W2);
		expect_write(`W5300_GAR, `GAR_W0);
		expect_write(`W5300_GAR + 10'd2, `GAR_W1);
		expect_write(`W5300_SUBR, `SUBR_W0);
		expect_write(`W5300_SUBR + 10'd2, `SUBR_W1);
		expect_write(`W5300_SIPR, `SIPR_W0);
		expect_write(`W5300_SIPR + 10'd2, `SIPR_W1);
		expect_write(`W5300_S0_MR, 16'h0002);    // udp
		expect_write(`W5300_S0_CR, 16'h0001);    // open
		expect_write(`W5300_S0_IMR, 16'h0004);
		expect_write(`W5300_S0_PORTR, 16'h1388); // port 5000
	endtask

	task automatic reset_dut();
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic wait_setup();
		while (!init_done && !init_fail)
			@(negedge clk);
	endtask

	task automatic send_packet(input int size);
		logic [7:0] b;
		int         i;
		int         first;
		int         start;
		int         hits;
		first = log_a.size();
		start = done_count;
		for (i = 0; i < size + (size % 2); i++) // odd sizes carry a pad byte
		begin
			b = 8'($urandom);
			if (i >= `UDP_INFO_LEN && i < size)
				exp_bytes.push_back(b);
			pkt_wr   = 1'b1;
			pkt_byte = b;
			@(negedge clk);
		end
		pkt_wr  = 1'b0;
		pkt_len = 17'(size);
		pkt_go  = 1'b1;
		@(negedge clk);
		pkt_go = 1'b0;
		while (done_count == start)
			@(negedge clk);
		repeat (20) @(negedge clk); // room for a stray byte
		expect_true(done_count == start + 1, $sformatf("rx_done count %0d", done_count - start));
		expect_true(exp_bytes.size() == 0, $sformatf("%0d bytes missing", exp_bytes.size()));
		hits = 0;
		for (i = first; i < log_a.size(); i++)
		begin
			if (log_a[i] == `W5300_S0_IR)
			begin
				hits++;
				expect_true(log_d[i] == `S0_RECV_IRQ, $sformatf("S0_IR written %h", log_d[i]));
			end
		end
		expect_true(hits == 1, $sformatf("%0d S0_IR writes for size %0d", hits, size));
	endtask

	always @(negedge clk)
		payload_ready = ready_en && ($urandom_range(3) != 0);

	always @(posedge clk)
	begin
		if (log_valid)
		begin
			log_a.push_back(log_addr);
			log_d.push_back(log_data);
		end
	end

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			expect_true(rd || wr, "rd and wr low together");
			expect_true(!cs || (rd && wr), "strobe low while cs high");
			if (!cs && !rd)
				expect_true(data == rd_byte, $sformatf("bus %h chip %h", data, rd_byte));
			if (init_fail)
				expect_true(cs && rd && wr, "bus active after open failure");
			if (payload_valid && payload_ready)
			begin
				if (exp_bytes.size() == 0)
					expect_true(1'b0, $sformatf("extra payload byte %h", payload_data));
				else
				begin
					want_byte = exp_bytes.pop_front();
					expect_true(payload_data == want_byte,
						$sformatf("payload %h expected %h", payload_data, want_byte));
				end
			end
			if (rx_done)
			begin
				done_count++;
				expect_true(take_q && exp_bytes.size() == 0, "rx_done not after the last byte");
			end
		end
		take_q <= payload_valid && payload_ready;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
			$display("checks %0d errors %0d", checks, errors);
			$display("sim failed");
			$finish;
		end
	end

	initial
	begin
		int i;
		void'($urandom(32'ha522));
		rst_n       = 1'b0;
		refuse_open = 1'b0;
		pkt_wr      = 1'b0;
		pkt_byte    = 8'h00;
		pkt_go      = 1'b0;
		pkt_len     = 17'd0;
		load_setup_list();
		reset_dut();
		wait_setup();
		expect_true(init_done && !init_fail, "setup did not end in done");
		expect_true(log_a.size() == `INIT_STEPS, $sformatf("%0d setup writes", log_a.size()));
		for (i = 0; i < `INIT_STEPS && i < log_a.size(); i++)
			expect_true(log_a[i] == want_a[i] && log_d[i] == want_d[i],
				$sformatf("setup write %0d got %h=%h expected %h=%h",
					i, log_a[i], log_d[i], want_a[i], want_d[i]));

		ready_en <= 1'b1; // back-pressure pattern starts with the next falling edge
		send_packet(16 + 2 * $urandom_range(24)); // even size
		send_packet(17 + 2 * $urandom_range(23)); // odd size with pad
		send_packet(16 + 2 * $urandom_range(24));
		send_packet(17 + 2 * $urandom_range(23));

		// socket never opens
		refuse_open = 1'b1;
		reset_dut();
		wait_setup();
		repeat (50) @(negedge clk);
		expect_true(init_fail && !init_done, "open failure not reported");
		expect_true(ssr_reads == 8'(`SSR_RETRIES), $sformatf("%0d SSR reads", ssr_reads));

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: test/w5300_model.sv
`include "w5300_defs.svh"

module w5300_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [9:0]  addr,
	input  logic        cs,
	input  logic        rd,
	input  logic        wr,
	inout  wire  [7:0]  data,
	output logic        int_n,
	output logic [7:0]  rd_byte,
	input  logic        refuse_open,
	input  logic        pkt_wr,
	input  logic [7:0]  pkt_byte,
	input  logic        pkt_go,
	input  logic [16:0] pkt_len,
	output logic        log_valid,
	output logic [9:0]  log_addr,
	output logic [15:0] log_data,
	output logic [7:0]  ssr_reads
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] regs [0:1023]; // indexed by even byte address
	logic [7:0]  fifo [0:255];
	logic [7:0]  wptr;
	logic [7:0]  rptr;          // high byte of the current FIFO word
	logic        wr_q;
	logic        rd_q;
	logic [9:0]  rd_addr;
	logic [9:0]  waddr;

	assign waddr = {addr[9:1], 1'b0};
	assign data  = (!cs && !rd) ? rd_byte : 8'hzz;

	always_comb
	begin
		if (waddr == `W5300_S0_RX_FIFOR)
			rd_byte = addr[0] ? fifo[rptr + 8'd1] : fifo[rptr];
		else
			rd_byte = addr[0] ? regs[waddr][7:0] : regs[waddr][15:8];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_n     <= 1'b1;
			wr_q      <= 1'b1;
			rd_q      <= 1'b1;
			rd_addr   <= '0;
			wptr      <= '0;
			rptr      <= '0;
			log_valid <= 1'b0;
			log_addr  <= '0;
			log_data  <= '0;
			ssr_reads <= '0;
			regs[`W5300_S0_SSR] <= 16'h0000; // socket closed
			regs[`W5300_IR]     <= 16'h0000;
		end
		else
		begin
			wr_q      <= wr;
			rd_q      <= rd;
			log_valid <= 1'b0;
			if (!cs && !wr && wr_q) // first clock of a write strobe
			begin
				if (addr[0])
				begin
					regs[waddr][7:0] <= data;
					log_valid        <= 1'b1; // word complete with its low byte
					log_addr         <= waddr;
					log_data         <= {regs[waddr][15:8], data};
					if (waddr == `W5300_S0_IR)
					begin
						int_n           <= 1'b1;
						regs[`W5300_IR] <= 16'h0000;
					end
					if (waddr == `W5300_S0_CR && data == 8'h01 && !refuse_open)
						regs[`W5300_S0_SSR] <= {8'h00, `SOCK_UDP};
				end
				else
					regs[waddr][15:8] <= data;
			end
			if (!cs && !rd && rd_q)
			begin
				rd_addr <= addr;
				if (addr == `W5300_S0_SSR)
					ssr_reads <= ssr_reads + 8'd1;
			end
			// low byte of a FIFO word finished
			if (rd && !rd_q && rd_addr == (`W5300_S0_RX_FIFOR | 10'd1))
				rptr <= rptr + 8'd2;
			if (pkt_wr)
			begin
				fifo[wptr] <= pkt_byte;
				wptr       <= wptr + 8'd1;
			end
			if (pkt_go)
			begin
				regs[`W5300_S0_RX_RSR]  <= {15'd0, pkt_len[16]};
				regs[`W5300_S0_RX_RSR2] <= pkt_len[15:0];
				regs[`W5300_IR]         <= 16'h0001; // socket 0 flag
				regs[`W5300_S0_IR]      <= `S0_RECV_IRQ;
				wptr                    <= '0;
				rptr                    <= '0;
				int_n                   <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/udp_unpack.sv
`include "w5300_defs.svh"

module udp_unpack
	import w5300_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        frame_start,
	input  logic [16:0] frame_len,
	input  logic        word_valid,
	input  w5300_word_t word_data,
	output logic        word_ready,
	output logic        payload_valid,
	output logic [7:0]  payload_data,
	input  logic        payload_ready,
	output logic        rx_done
);

	logic        full; // word held
	logic        sel;  // 0 high byte, 1 low byte
	w5300_word_t hold;
	logic [16:0] idx;  // byte position in the frame
	logic [16:0] len;
	logic        keep;
	logic        adv;

	assign word_ready    = !full;
	assign keep          = (idx >= 17'(`UDP_INFO_LEN)) && (idx < len);
	assign payload_valid = full && keep;
	assign payload_data  = sel ? hold.bytes.lo : hold.bytes.hi;
	// header and pad bytes drop without waiting for ready
	assign adv           = full && (!keep || payload_ready);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			full    <= 1'b0;
			sel     <= 1'b0;
			idx     <= 17'd0;
			len     <= 17'd0;
			rx_done <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			if (frame_start)
			begin
				idx <= 17'd0;
				len <= frame_len;
			end
			else if (adv)
			begin
				idx <= idx + 17'd1;
				sel <= !sel;
				if (sel)
					full <= 1'b0;
				if (idx == len - 17'd1)
					rx_done <= 1'b1; // last real byte gone
			end
			if (word_valid && word_ready)
			begin
				full <= 1'b1;
				sel  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (word_valid && word_ready)
			hold <= word_data;
	end

endmodule

// File: verilog/w5300_bus.sv
`include "w5300_defs.svh"

module w5300_bus
	import w5300_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        req_valid,
	input  logic        req_write,
	input  w5300_addr_t req_addr,
	input  w5300_word_t req_wdata,
	output logic        req_ready,
	output logic        rsp_valid,
	output w5300_word_t rsp_rdata,
	output logic [9:0]  addr,
	output logic        cs,
	output logic        rd,
	output logic        wr,
	inout  wire  [7:0]  data
);

	localparam int BYTE_LEN  = `BUS_SETUP + `BUS_STROBE + `BUS_HOLD;
	localparam int STB_FIRST = `BUS_SETUP;
	localparam int STB_LAST  = `BUS_SETUP + `BUS_STROBE - 1;

	logic        busy;
	logic        lo_sel; // second byte of the word
	logic [2:0]  ph;
	logic        op_write;
	w5300_addr_t op_addr;
	w5300_word_t op_data;
	w5300_word_t rd_word; // assembled read data
	logic        strobe;
	logic [7:0]  wbyte;

	assign req_ready = !busy;
	assign strobe    = busy && (ph >= 3'(STB_FIRST)) && (ph <= 3'(STB_LAST));
	assign wbyte     = lo_sel ? op_data.bytes.lo : op_data.bytes.hi;

	assign addr = {op_addr[9:1], lo_sel}; // high byte sits at the even address
	assign cs   = !busy;
	assign rd   = !(strobe && !op_write);
	assign wr   = !(strobe && op_write);
	assign data = (strobe && op_write) ? wbyte : 8'hzz;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			lo_sel    <= 1'b0;
			ph        <= 3'd0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			rsp_valid <= 1'b0;
			if (!busy)
			begin
				if (req_valid)
				begin
					busy   <= 1'b1;
					ph     <= 3'd0;
					lo_sel <= 1'b0;
				end
			end
			else if (ph == 3'(BYTE_LEN - 1))
			begin
				ph <= 3'd0;
				if (lo_sel)
				begin
					busy      <= 1'b0; // both bytes done
					lo_sel    <= 1'b0;
					rsp_valid <= 1'b1;
				end
				else
					lo_sel <= 1'b1;
			end
			else
				ph <= ph + 3'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
		begin
			op_write <= req_write;
			op_addr  <= req_addr;
			op_data  <= req_wdata;
		end
		// sample at the last strobe clock, writes echo their own data
		if (busy && ph == 3'(STB_LAST))
		begin
			if (lo_sel)
				rd_word.bytes.lo <= op_write ? op_data.bytes.lo : data;
			else
				rd_word.bytes.hi <= op_write ? op_data.bytes.hi : data;
		end
		if (busy && lo_sel && ph == 3'(BYTE_LEN - 1))
			rsp_rdata <= rd_word; // stable until the next response
	end

endmodule

// File: verilog/w5300_init_rom.sv
`include "w5300_defs.svh"

module w5300_init_rom
	import w5300_pkg::*;
(
	input  logic [3:0]  step,
	output w5300_addr_t init_addr,
	output w5300_word_t init_data
);

	always_comb
	begin
		init_addr = `W5300_IMR;
		init_data = `IMR_S0_EN;
		case (step)
			4'd0:
			begin
				init_addr = `W5300_IMR; // socket 0 interrupt only
				init_data = `IMR_S0_EN;
			end
			4'd1:
			begin
				init_addr = `W5300_SHAR;
				init_data = `MAC_W0;
			end
			4'd2:
			begin
				init_addr = `W5300_SHAR + 10'd2;
				init_data = `MAC_W1;
			end
			4'd3:
			begin
				init_addr = `W5300_SHAR + 10'd4;
				init_data = `MAC_W2;
			end
			4'd4:
			begin
				init_addr = `W5300_GAR;
				init_data = `GAR_W0;
			end
			4'd5:
			begin
				init_addr = `W5300_GAR + 10'd2;
				init_data = `GAR_W1;
			end
			4'd6:
			begin
				init_addr = `W5300_SUBR;
				init_data = `SUBR_W0;
			end
			4'd7:
			begin
				init_addr = `W5300_SUBR + 10'd2;
				init_data = `SUBR_W1;
			end
			4'd8:
			begin
				init_addr = `W5300_SIPR;
				init_data = `SIPR_W0;
			end
			4'd9:
			begin
				init_addr = `W5300_SIPR + 10'd2;
				init_data = `SIPR_W1;
			end
			4'd10:
			begin
				init_addr = `W5300_S0_MR; // udp mode
				init_data = `SN_MR_UDP;
			end
			4'd11:
			begin
				init_addr = `W5300_S0_CR; // open command
				init_data = `SN_CR_OPEN;
			end
			4'd12:
			begin
				init_addr = `W5300_S0_IMR; // recv interrupt enable
				init_data = `S0_RECV_IRQ;
			end
			4'd13:
			begin
				init_addr = `W5300_S0_PORTR;
				init_data = `UDP_PORT;
			end
			default:
			begin
				init_addr = `W5300_IMR;
				init_data = `IMR_S0_EN;
			end
		endcase
	end

endmodule

// File: verilog/w5300_pkg.sv
package w5300_pkg;

	// word address on the chip pins
	typedef logic [9:0] w5300_addr_t;

	typedef struct packed {
		logic [7:0] hi; // even address
		logic [7:0] lo;
	} w5300_bytes_t;

	// interrupt register layout
	typedef struct packed {
		logic       ipcf; // ip conflict
		logic       dpur; // dest port unreachable
		logic       pppt; // pppoe terminated
		logic       fmtu; // fragment mtu
		logic [3:0] rsvd;
		logic [7:0] sock; // one bit per socket
	} w5300_ir_t;

	typedef union packed {
		w5300_bytes_t bytes;
		w5300_ir_t    ir;
	} w5300_word_t;

endpackage

// File: verilog/w5300_seq.sv
`include "w5300_defs.svh"

module w5300_seq
	import w5300_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        int_n,
	output logic        req_valid,
	output logic        req_write,
	output w5300_addr_t req_addr,
	output w5300_word_t req_wdata,
	input  logic        req_ready,
	input  logic        rsp_valid,
	input  w5300_word_t rsp_rdata,
	output logic [3:0]  init_step,
	input  w5300_addr_t init_addr,
	input  w5300_word_t init_data,
	output logic        frame_start,
	output logic [16:0] frame_len,
	output logic        word_valid,
	output w5300_word_t word_data,
	input  logic        word_ready,
	output logic        init_done,
	output logic        init_fail
);

	typedef enum logic [3:0] {
		S_INIT,
		S_SSR_RD,
		S_SSR_WAIT,
		S_IDLE,
		S_IR_RD,
		S_IR_CLR,
		S_RSR_RD,
		S_RSR2_RD,
		S_FRAME,
		S_FIFO_RD,
		S_FWD,
		S_FAIL
	} state_t;

	state_t      state;
	logic        sent; // request taken, response pending
	logic        issue;
	logic [3:0]  step;
	logic [1:0]  retry;
	logic [6:0]  wait_cnt;
	logic [16:0] rx_len;
	logic [16:0] words_left;
	w5300_word_t word_q;

	assign init_step   = step;
	assign req_valid   = issue && !sent;
	assign frame_start = (state == S_FRAME) && (rx_len != 17'd0);
	assign frame_len   = rx_len;
	assign word_data   = word_q;

	// request fields follow the state and stay put until taken
	always_comb
	begin
		issue     = 1'b1;
		req_write = 1'b0;
		req_addr  = `W5300_IR;
		req_wdata = '0;
		case (state)
			S_INIT:
			begin
				req_write = 1'b1;
				req_addr  = init_addr;
				req_wdata = init_data;
			end
			S_SSR_RD:
				req_addr = `W5300_S0_SSR;
			S_IR_RD:
				req_addr = `W5300_IR;
			S_IR_CLR:
			begin
				req_write = 1'b1;
				req_addr  = `W5300_S0_IR;
				req_wdata = `S0_RECV_IRQ; // write one to clear recv
			end
			S_RSR_RD:
				req_addr = `W5300_S0_RX_RSR;
			S_RSR2_RD:
				req_addr = `W5300_S0_RX_RSR2;
			S_FIFO_RD:
				req_addr = `W5300_S0_RX_FIFOR;
			default:
				issue = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= S_INIT;
			sent       <= 1'b0;
			step       <= 4'd0;
			retry      <= 2'd0;
			wait_cnt   <= 7'd0;
			rx_len     <= 17'd0;
			words_left <= 17'd0;
			word_valid <= 1'b0;
			init_done  <= 1'b0;
			init_fail  <= 1'b0;
		end
		else
		begin
			if (req_valid && req_ready)
				sent <= 1'b1;
			if (rsp_valid)
				sent <= 1'b0;

			case (state)
				S_INIT:
					if (rsp_valid)
					begin
						if (step == 4'(`INIT_STEPS - 1))
							state <= S_SSR_RD;
						else
							step <= step + 4'd1;
					end
				S_SSR_RD:
					if (rsp_valid)
					begin
						if (rsp_rdata.bytes.lo == `SOCK_UDP)
						begin
							init_done <= 1'b1;
							state     <= S_IDLE;
						end
						else if (retry == 2'(`SSR_RETRIES - 1))
						begin
							init_fail <= 1'b1; // give up, bus stays quiet
							state     <= S_FAIL;
						end
						else
						begin
							retry    <= retry + 2'd1;
							wait_cnt <= 7'd0;
							state    <= S_SSR_WAIT;
						end
					end
				S_SSR_WAIT:
					if (wait_cnt == 7'(`SSR_WAIT - 1))
						state <= S_SSR_RD;
					else
						wait_cnt <= wait_cnt + 7'd1;
				S_IDLE:
					if (!int_n)
						state <= S_IR_RD;
				S_IR_RD:
					if (rsp_valid)
						state <= rsp_rdata.ir.sock[0] ? S_IR_CLR : S_IDLE;
				S_IR_CLR:
					if (rsp_valid)
						state <= S_RSR_RD;
				S_RSR_RD:
					if (rsp_valid)
					begin
						rx_len[16] <= rsp_rdata[0]; // size msb
						state      <= S_RSR2_RD;
					end
				S_RSR2_RD:
					if (rsp_valid)
					begin
						rx_len[15:0] <= rsp_rdata;
						state        <= S_FRAME;
					end
				S_FRAME:
				begin
					words_left <= 17'((18'(rx_len) + 18'd1) >> 1); // round up to words
					state      <= (rx_len == 17'd0) ? S_IDLE : S_FIFO_RD;
				end
				S_FIFO_RD:
					if (rsp_valid)
					begin
						word_valid <= 1'b1;
						state      <= S_FWD;
					end
				S_FWD:
					if (word_ready)
					begin
						word_valid <= 1'b0;
						words_left <= words_left - 17'd1;
						state      <= (words_left == 17'd1) ? S_IDLE : S_FIFO_RD;
					end
				default:
					state <= S_FAIL;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_FIFO_RD && rsp_valid)
			word_q <= rsp_rdata;
	end

endmodule

// File: verilog/w5300_udp_bridge.sv
module w5300_udp_bridge
	import w5300_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       int_n,
	output logic [9:0] addr,
	output logic       cs,
	output logic       rd,
	output logic       wr,
	inout  wire  [7:0] data,
	output logic       payload_valid,
	output logic [7:0] payload_data,
	input  logic       payload_ready,
	output logic       rx_done,
	output logic       init_done,
	output logic       init_fail
);

	logic        req_valid;
	logic        req_write;
	logic        req_ready;
	w5300_addr_t req_addr;
	w5300_word_t req_wdata;
	logic        rsp_valid;
	w5300_word_t rsp_rdata;
	logic [3:0]  init_step;
	w5300_addr_t init_addr;
	w5300_word_t init_data;
	logic        frame_start;
	logic [16:0] frame_len;
	logic        word_valid;
	logic        word_ready;
	w5300_word_t word_data;

	w5300_bus u_bus (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.addr      (addr),
		.cs        (cs),
		.rd        (rd),
		.wr        (wr),
		.data      (data)
	);

	w5300_init_rom u_rom (
		.step      (init_step),
		.init_addr (init_addr),
		.init_data (init_data)
	);

	w5300_seq u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.int_n       (int_n),
		.req_valid   (req_valid),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.req_ready   (req_ready),
		.rsp_valid   (rsp_valid),
		.rsp_rdata   (rsp_rdata),
		.init_step   (init_step),
		.init_addr   (init_addr),
		.init_data   (init_data),
		.frame_start (frame_start),
		.frame_len   (frame_len),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_ready  (word_ready),
		.init_done   (init_done),
		.init_fail   (init_fail)
	);

	udp_unpack u_unpack (
		.clk           (clk),
		.rst_n         (rst_n),
		.frame_start   (frame_start),
		.frame_len     (frame_len),
		.word_valid    (word_valid),
		.word_data     (word_data),
		.word_ready    (word_ready),
		.payload_valid (payload_valid),
		.payload_data  (payload_data),
		.payload_ready (payload_ready),
		.rx_done       (rx_done)
	);

endmodule
